/* filelist.f */
+incdir+src
src/decode_pkg.sv
src/instr_decoder.sv
src/decode_skid_buffer.sv
src/operand_issue.sv
src/decode_stage.sv
tests/decode_stage_sva.sv
tests/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f filelist.f --top-module decode_stage_tb

output=$(./obj_dir/Vdecode_stage_tb 2>&1) || true
echo "$output"
echo "$output" | grep -q "All tests passed"

/* src/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath widths
`define XLEN        32
`define ILEN        32
`define REG_ADDR_W  5

// Major opcodes, instr[6:2]
`define OPC_LUI       5'b01101
`define OPC_AUIPC     5'b00101
`define OPC_JAL       5'b11011
`define OPC_JALR      5'b11001
`define OPC_BRANCH    5'b11000
`define OPC_LOAD      5'b00000
`define OPC_STORE     5'b01000
`define OPC_OP_IMM    5'b00100
`define OPC_OP        5'b01100
`define OPC_MISC_MEM  5'b00011
`define OPC_SYSTEM    5'b11100

`define BUF_DEPTH   2   // Entries between decoder and issue

`endif

/* src/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`ILEN-1:0]       instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Base integer operations only
    typedef enum logic [5:0] {
        NOP, INVALID_OP,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ECALL, EBREAK, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        op_e       op;
        format_e   fmt;
        word_t     pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      use_rs1;
        logic      use_rs2;
        logic      is_load;
        logic      illegal;
        logic      misaligned;
    } decoded_pkt_t;

    typedef struct packed {
        op_e       op;
        word_t     pc;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     second_operand;
        word_t     jump_target;
        word_t     pc_next;
        logic      exc_illegal;
        logic      exc_misaligned;
    } exec_pkt_t;

endpackage

/* src/decode_skid_buffer.sv */
`include "decode_params.svh"

module decode_skid_buffer (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  decode_pkg::decoded_pkt_t in_pkt_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output decode_pkg::decoded_pkt_t out_pkt_o
);

    localparam int PTR_W = (`BUF_DEPTH > 1) ? $clog2(`BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

    decode_pkg::decoded_pkt_t mem [`BUF_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     push;
    logic                     pop;

    // Wraps at any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(`BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready_o  = (count != CNT_W'(`BUF_DEPTH));
    assign out_valid_o = (count != '0);
    assign out_pkt_o   = mem[rd_ptr];   // Oldest entry
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_pkt_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or pass-through
            endcase
        end
    end

endmodule

/* src/decode_stage.sv */
module decode_stage (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  decode_pkg::fetch_pkt_t fetch_pkt_i,
    output decode_pkg::reg_addr_t  rs1_addr_o,
    output decode_pkg::reg_addr_t  rs2_addr_o,
    input  decode_pkg::word_t      rs1_data_i,
    input  decode_pkg::word_t      rs2_data_i,
    output logic                   exec_valid_o,
    input  logic                   exec_ready_i,
    output decode_pkg::exec_pkt_t  exec_pkt_o
);

    decode_pkg::decoded_pkt_t dec_pkt;
    decode_pkg::decoded_pkt_t head_pkt;
    logic                     head_valid;
    logic                     head_ready;

    instr_decoder u_decoder (
        .fetch_pkt_i (fetch_pkt_i),
        .dec_pkt_o   (dec_pkt)
    );

    decode_skid_buffer u_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid_i  (fetch_valid_i),
        .in_ready_o  (fetch_ready_o),
        .in_pkt_i    (dec_pkt),
        .out_valid_o (head_valid),
        .out_ready_i (head_ready),
        .out_pkt_o   (head_pkt)
    );

    operand_issue u_issue (
        .clk          (clk),
        .reset_n      (reset_n),
        .head_valid_i (head_valid),
        .head_ready_o (head_ready),
        .head_pkt_i   (head_pkt),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .exec_valid_o (exec_valid_o),
        .exec_ready_i (exec_ready_i),
        .exec_pkt_o   (exec_pkt_o)
    );

endmodule

/* src/instr_decoder.sv */
`include "decode_params.svh"

module instr_decoder (
    input  decode_pkg::fetch_pkt_t   fetch_pkt_i,
    output decode_pkg::decoded_pkt_t dec_pkt_o
);

    decode_pkg::instr_t  instr;
    logic [4:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    decode_pkg::op_e     op;
    decode_pkg::op_e     op_branch;
    decode_pkg::op_e     op_load;
    decode_pkg::op_e     op_store;
    decode_pkg::op_e     op_imm;
    decode_pkg::op_e     op_reg;
    decode_pkg::op_e     op_system;
    decode_pkg::format_e fmt;
    decode_pkg::word_t   imm;
    logic                use_rs1;
    logic                use_rs2;

    assign instr  = fetch_pkt_i.instr;
    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////////////////////////
    // Per-class operation tables
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = decode_pkg::BEQ;
            3'b001:  op_branch = decode_pkg::BNE;
            3'b100:  op_branch = decode_pkg::BLT;
            3'b101:  op_branch = decode_pkg::BGE;
            3'b110:  op_branch = decode_pkg::BLTU;
            3'b111:  op_branch = decode_pkg::BGEU;
            default: op_branch = decode_pkg::INVALID_OP;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = decode_pkg::LB;
            3'b001:  op_load = decode_pkg::LH;
            3'b010:  op_load = decode_pkg::LW;
            3'b100:  op_load = decode_pkg::LBU;
            3'b101:  op_load = decode_pkg::LHU;
            default: op_load = decode_pkg::INVALID_OP;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = decode_pkg::SB;
            3'b001:  op_store = decode_pkg::SH;
            3'b010:  op_store = decode_pkg::SW;
            default: op_store = decode_pkg::INVALID_OP;
        endcase
    end

    // Shifts are the only immediates that constrain funct7
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????000: op_imm = decode_pkg::ADD;
            10'b0000000001: op_imm = decode_pkg::SLL;
            10'b???????010: op_imm = decode_pkg::SLT;
            10'b???????011: op_imm = decode_pkg::SLTU;
            10'b???????100: op_imm = decode_pkg::XOR;
            10'b0000000101: op_imm = decode_pkg::SRL;
            10'b0100000101: op_imm = decode_pkg::SRA;
            10'b???????110: op_imm = decode_pkg::OR;
            10'b???????111: op_imm = decode_pkg::AND;
            default:        op_imm = decode_pkg::INVALID_OP;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000000: op_reg = decode_pkg::ADD;
            10'b0100000000: op_reg = decode_pkg::SUB;
            10'b0000000001: op_reg = decode_pkg::SLL;
            10'b0000000010: op_reg = decode_pkg::SLT;
            10'b0000000011: op_reg = decode_pkg::SLTU;
            10'b0000000100: op_reg = decode_pkg::XOR;
            10'b0000000101: op_reg = decode_pkg::SRL;
            10'b0100000101: op_reg = decode_pkg::SRA;
            10'b0000000110: op_reg = decode_pkg::OR;
            10'b0000000111: op_reg = decode_pkg::AND;
            default:        op_reg = decode_pkg::INVALID_OP;
        endcase
    end

    // Privileged forms need rs1 and rd both zero
    always_comb begin
        case (funct3)
            3'b000: begin
                case ({instr[31:20], instr[19:15], instr[11:7]})
                    22'h000000: op_system = decode_pkg::ECALL;
                    22'h000400: op_system = decode_pkg::EBREAK;
                    22'h0C0800: op_system = decode_pkg::MRET;
                    22'h041400: op_system = decode_pkg::WFI;
                    default:    op_system = decode_pkg::INVALID_OP;
                endcase
            end
            3'b001:  op_system = decode_pkg::CSRRW;
            3'b010:  op_system = decode_pkg::CSRRS;
            3'b011:  op_system = decode_pkg::CSRRC;
            3'b101:  op_system = decode_pkg::CSRRWI;
            3'b110:  op_system = decode_pkg::CSRRSI;
            3'b111:  op_system = decode_pkg::CSRRCI;
            default: op_system = decode_pkg::INVALID_OP;
        endcase
    end

    always_comb begin
        case (opcode)
            `OPC_LUI:      op = decode_pkg::LUI;
            `OPC_AUIPC:    op = decode_pkg::AUIPC;
            `OPC_JAL:      op = decode_pkg::JAL;
            `OPC_JALR:     op = (funct3 == 3'b000) ? decode_pkg::JALR : decode_pkg::INVALID_OP;
            `OPC_BRANCH:   op = op_branch;
            `OPC_LOAD:     op = op_load;
            `OPC_STORE:    op = op_store;
            `OPC_OP_IMM:   op = op_imm;
            `OPC_OP:       op = op_reg;
            `OPC_MISC_MEM: op = (funct3 == 3'b000) ? decode_pkg::NOP : decode_pkg::INVALID_OP;
            `OPC_SYSTEM:   op = op_system;
            default:       op = decode_pkg::INVALID_OP;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Format, immediate and source usage
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: fmt = decode_pkg::I_TYPE;
            `OPC_STORE:                        fmt = decode_pkg::S_TYPE;
            `OPC_BRANCH:                       fmt = decode_pkg::B_TYPE;
            `OPC_LUI, `OPC_AUIPC:              fmt = decode_pkg::U_TYPE;
            `OPC_JAL:                          fmt = decode_pkg::J_TYPE;
            default:                           fmt = decode_pkg::R_TYPE;
        endcase
    end

    always_comb begin
        case (fmt)
            decode_pkg::I_TYPE: imm = {{21{instr[31]}}, instr[30:20]};
            decode_pkg::S_TYPE: imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            decode_pkg::B_TYPE: imm = {{20{instr[31]}}, instr[7], instr[30:25],
                                       instr[11:8], 1'b0};
            decode_pkg::U_TYPE: imm = {instr[31:12], 12'b0};
            decode_pkg::J_TYPE: imm = {{12{instr[31]}}, instr[19:12], instr[20],
                                       instr[30:21], 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            `OPC_BRANCH, `OPC_STORE, `OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: use_rs1 = 1'b1;
            `OPC_SYSTEM: use_rs1 = !funct3[2] && (funct3 != 3'b000); // CSR register forms
            default: ;
        endcase
    end

    always_comb begin
        dec_pkt_o.op         = op;
        dec_pkt_o.fmt        = fmt;
        dec_pkt_o.pc         = fetch_pkt_i.pc;
        dec_pkt_o.rd         = instr[11:7];
        dec_pkt_o.rs1        = instr[19:15];
        dec_pkt_o.rs2        = instr[24:20];
        dec_pkt_o.imm        = imm;
        dec_pkt_o.use_rs1    = use_rs1;
        dec_pkt_o.use_rs2    = use_rs2;
        dec_pkt_o.illegal    = (instr[1:0] != 2'b11) || (op == decode_pkg::INVALID_OP);
        dec_pkt_o.is_load    = (opcode == `OPC_LOAD) && !dec_pkt_o.illegal;
        dec_pkt_o.misaligned = (fetch_pkt_i.pc[1:0] != 2'b00);  // No compressed support
    end

endmodule

/* src/operand_issue.sv */
module operand_issue (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     head_valid_i,
    output logic                     head_ready_o,
    input  decode_pkg::decoded_pkt_t head_pkt_i,
    output decode_pkg::reg_addr_t    rs1_addr_o,
    output decode_pkg::reg_addr_t    rs2_addr_o,
    input  decode_pkg::word_t        rs1_data_i,
    input  decode_pkg::word_t        rs2_data_i,
    output logic                     exec_valid_o,
    input  logic                     exec_ready_i,
    output decode_pkg::exec_pkt_t    exec_pkt_o
);

    decode_pkg::reg_addr_t lock_rd;     // Zero when no lock
    decode_pkg::exec_pkt_t next_pkt;
    logic                  out_is_load;
    logic                  has_exc;
    logic                  lock_hit;
    logic                  pend_hit;
    logic                  out_free;
    logic                  head_fire;
    logic                  exec_fire;

    function automatic logic src_match(input decode_pkg::decoded_pkt_t p,
                                       input decode_pkg::reg_addr_t    r);
        src_match = (r != '0) && ((p.use_rs1 && p.rs1 == r) || (p.use_rs2 && p.rs2 == r));
    endfunction

    ////////////////////////////////////////////////////////////
    // Load-use lock
    ////////////////////////////////////////////////////////////

    assign has_exc   = head_pkt_i.illegal || head_pkt_i.misaligned;
    assign lock_hit  = src_match(head_pkt_i, lock_rd);
    // A load still waiting in the output register blocks its consumers too
    assign pend_hit  = exec_valid_o && out_is_load && src_match(head_pkt_i, exec_pkt_o.rd);
    assign out_free  = !exec_valid_o || exec_ready_i;
    assign head_ready_o = out_free && !((lock_hit || pend_hit) && !has_exc);
    assign head_fire = head_valid_i && head_ready_o;
    assign exec_fire = exec_valid_o && exec_ready_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lock_rd <= '0;
        end else begin
            lock_rd <= (exec_fire && out_is_load) ? exec_pkt_o.rd : '0;   // One cycle only
        end
    end

    ////////////////////////////////////////////////////////////
    // Operands and output register
    ////////////////////////////////////////////////////////////

    assign rs1_addr_o = head_pkt_i.rs1;
    assign rs2_addr_o = head_pkt_i.rs2;

    always_comb begin
        next_pkt.op  = head_pkt_i.illegal ? decode_pkg::INVALID_OP : head_pkt_i.op;
        next_pkt.pc  = head_pkt_i.pc;
        next_pkt.rd  = head_pkt_i.rd;
        next_pkt.rs1_data = rs1_data_i;
        next_pkt.rs2_data = rs2_data_i;
        case (head_pkt_i.fmt)
            decode_pkg::I_TYPE,
            decode_pkg::S_TYPE,
            decode_pkg::U_TYPE: next_pkt.second_operand = head_pkt_i.imm;
            default:            next_pkt.second_operand = rs2_data_i;
        endcase
        next_pkt.jump_target    = head_pkt_i.pc + head_pkt_i.imm;
        next_pkt.pc_next        = head_pkt_i.pc + 32'd4;    // Link address
        next_pkt.exc_illegal    = head_pkt_i.illegal;
        next_pkt.exc_misaligned = head_pkt_i.misaligned;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exec_valid_o <= 1'b0;
        end else if (head_fire) begin
            exec_valid_o <= 1'b1;
        end else if (exec_fire) begin
            exec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (head_fire) begin
            exec_pkt_o  <= next_pkt;
            out_is_load <= head_pkt_i.is_load && !has_exc;
        end
    end

endmodule

/* tests/decode_stage_sva.sv */
module decode_stage_sva (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     head_valid_i,
    input logic                     head_ready_o,
    input decode_pkg::decoded_pkt_t head_pkt_i,
    input logic                     exec_valid_o,
    input logic                     exec_ready_i,
    input decode_pkg::exec_pkt_t    exec_pkt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    decode_pkg::reg_addr_t last_rd;     // rd seen at execute one cycle ago
    logic                  load_fire;
    logic                  head_take;
    logic                  reads_last_rd;

    assign load_fire = exec_valid_o && exec_ready_i && (exec_pkt_o.rd != '0) &&
                       (exec_pkt_o.op inside {decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
                                              decode_pkg::LBU, decode_pkg::LHU});
    assign head_take = head_valid_i && head_ready_o &&
                       !head_pkt_i.illegal && !head_pkt_i.misaligned;
    assign reads_last_rd = (head_pkt_i.use_rs1 && head_pkt_i.rs1 == last_rd) ||
                           (head_pkt_i.use_rs2 && head_pkt_i.rs2 == last_rd);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_rd <= '0;
        end else begin
            last_rd <= exec_pkt_o.rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshake stability
    ////////////////////////////////////////////////////////////

    exec_hold: assert property (@(posedge clk) disable iff (!reset_n)
        exec_valid_o && !exec_ready_i |=> exec_valid_o && $stable(exec_pkt_o))
        else $error("exec payload dropped or changed while stalled");

    head_hold: assert property (@(posedge clk) disable iff (!reset_n)
        head_valid_i && !head_ready_o |=> head_valid_i && $stable(head_pkt_i))
        else $error("buffer head dropped or changed while held");

    // Consumer of a load waits out the lock cycle
    lock_hold: assert property (@(posedge clk) disable iff (!reset_n)
        load_fire |=> !(head_take && reads_last_rd))
        else $error("load consumer issued in the lock cycle");

endmodule

bind operand_issue decode_stage_sva u_sva (
    .clk          (clk),
    .reset_n      (reset_n),
    .head_valid_i (head_valid_i),
    .head_ready_o (head_ready_o),
    .head_pkt_i   (head_pkt_i),
    .exec_valid_o (exec_valid_o),
    .exec_ready_i (exec_ready_i),
    .exec_pkt_o   (exec_pkt_o)
);

/* tests/decode_stage_tb.sv */
`include "decode_params.svh"

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_VECTORS = 26;

    typedef struct packed {
        decode_pkg::word_t  pc;
        decode_pkg::instr_t instr;
        decode_pkg::op_e    op;     // Expected operation
    } vector_t;

    logic                   clk;
    logic                   reset_n;
    logic                   fetch_valid;
    logic                   fetch_ready;
    decode_pkg::fetch_pkt_t fetch_pkt;
    decode_pkg::reg_addr_t  rs1_addr;
    decode_pkg::reg_addr_t  rs2_addr;
    decode_pkg::word_t      rs1_data;
    decode_pkg::word_t      rs2_data;
    logic                   exec_valid;
    logic                   exec_ready;
    decode_pkg::exec_pkt_t  exec_pkt;

    vector_t               vectors [NUM_VECTORS];
    decode_pkg::exec_pkt_t exp_q [$];
    decode_pkg::exec_pkt_t expected;
    int                    error_count = 0;
    int                    out_count = 0;

    decode_stage dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .fetch_valid_i (fetch_valid),
        .fetch_ready_o (fetch_ready),
        .fetch_pkt_i   (fetch_pkt),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .exec_valid_o  (exec_valid),
        .exec_ready_i  (exec_ready),
        .exec_pkt_o    (exec_pkt)
    );

    ////////////////////////////////////////////////////////////
    // Register file and reference model
    ////////////////////////////////////////////////////////////

    function automatic decode_pkg::word_t reg_value(input decode_pkg::reg_addr_t addr);
        return (addr == '0) ? 32'd0 : (32'hC0DE_0000 + 32'(addr) * 32'h0000_0101);
    endfunction

    always_comb rs1_data = reg_value(rs1_addr);
    always_comb rs2_data = reg_value(rs2_addr);

    function automatic decode_pkg::exec_pkt_t expected_exec(input vector_t v);
        decode_pkg::exec_pkt_t e;
        decode_pkg::word_t     imm;
        decode_pkg::instr_t    w;
        logic                  use_imm;
        w = v.instr;
        use_imm = 1'b1;
        case (w[6:2])
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: imm = {{20{w[31]}}, w[31:20]};
            `OPC_STORE:                        imm = {{20{w[31]}}, w[31:25], w[11:7]};
            `OPC_LUI, `OPC_AUIPC:              imm = {w[31:12], 12'h000};
            `OPC_BRANCH: begin
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                use_imm = 1'b0;
            end
            `OPC_JAL: begin
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                use_imm = 1'b0;
            end
            default: begin
                imm = '0;       // R format and SYSTEM
                use_imm = 1'b0;
            end
        endcase
        e.op             = v.op;
        e.pc             = v.pc;
        e.rd             = w[11:7];
        e.rs1_data       = reg_value(w[19:15]);
        e.rs2_data       = reg_value(w[24:20]);
        e.second_operand = use_imm ? imm : e.rs2_data;
        e.jump_target    = v.pc + imm;
        e.pc_next        = v.pc + 32'd4;
        e.exc_illegal    = (v.op == decode_pkg::INVALID_OP);
        e.exc_misaligned = (v.pc[1:0] != 2'b00);
        return e;
    endfunction

    task automatic set_vector(input int idx, input decode_pkg::word_t addr,
                              input decode_pkg::instr_t word, input decode_pkg::op_e op_exp);
        vectors[idx] = '{pc: addr, instr: word, op: op_exp};
    endtask

    task automatic build_table();
        set_vector(0,  32'h0000_1000, 32'h1234_50B7, decode_pkg::LUI);
        set_vector(1,  32'h0000_1004, 32'hFFFF_F117, decode_pkg::AUIPC);
        set_vector(2,  32'h0000_1008, 32'hFFB0_8193, decode_pkg::ADD);    // addi x3,x1,-5
        set_vector(3,  32'h0000_100C, 32'h0081_2283, decode_pkg::LW);     // lw x5
        set_vector(4,  32'h0000_1010, 32'h0032_8333, decode_pkg::ADD);    // Uses x5
        set_vector(5,  32'h0000_1014, 32'hFFC3_1383, decode_pkg::LH);     // lh x7
        set_vector(6,  32'h0000_1018, 32'h0020_C433, decode_pkg::XOR);    // Independent
        set_vector(7,  32'h0000_101C, 32'h0074_2623, decode_pkg::SW);
        set_vector(8,  32'h0000_1020, 32'hFE20_8863, decode_pkg::BEQ);    // Offset -2064
        set_vector(9,  32'h0000_1024, 32'h0010_00EF, decode_pkg::JAL);    // Offset 2048
        set_vector(10, 32'h0000_1028, 32'h0040_8067, decode_pkg::JALR);
        set_vector(11, 32'h0000_102C, 32'h4071_D493, decode_pkg::SRA);    // srai
        set_vector(12, 32'h0000_1030, 32'h4062_8533, decode_pkg::SUB);
        set_vector(13, 32'h0000_1034, 32'h0FF0_000F, decode_pkg::NOP);    // fence
        set_vector(14, 32'h0000_1038, 32'h0000_0073, decode_pkg::ECALL);
        set_vector(15, 32'h0000_103C, 32'h0010_0073, decode_pkg::EBREAK);
        set_vector(16, 32'h0000_1040, 32'h3020_0073, decode_pkg::MRET);
        set_vector(17, 32'h0000_1044, 32'h1050_0073, decode_pkg::WFI);
        set_vector(18, 32'h0000_1048, 32'h3000_95F3, decode_pkg::CSRRW);
        set_vector(19, 32'h0000_104C, 32'h3052_E673, decode_pkg::CSRRSI);
        set_vector(20, 32'h0000_1050, 32'h0000_007F, decode_pkg::INVALID_OP); // No such opcode
        set_vector(21, 32'h0000_1054, 32'h0000_0010, decode_pkg::INVALID_OP); // Low bits 00
        set_vector(22, 32'h0000_1002, 32'h0010_8093, decode_pkg::ADD);    // Misaligned pc
        set_vector(23, 32'h0000_1058, 32'h0000_C683, decode_pkg::LBU);    // lbu x13
        set_vector(24, 32'h0000_105C, 32'h00D6_E733, decode_pkg::OR);     // x13 on both sides
        set_vector(25, 32'h0000_1060, 32'hFE21_8FA3, decode_pkg::SB);     // Offset -1
    endtask

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_exec(input decode_pkg::exec_pkt_t got,
                                input decode_pkg::exec_pkt_t exp);
        check_field("op", 32'(got.op), 32'(exp.op));
        check_field("pc", got.pc, exp.pc);
        check_field("rd", 32'(got.rd), 32'(exp.rd));
        check_field("rs1_data", got.rs1_data, exp.rs1_data);
        check_field("rs2_data", got.rs2_data, exp.rs2_data);
        check_field("second_operand", got.second_operand, exp.second_operand);
        check_field("jump_target", got.jump_target, exp.jump_target);
        check_field("pc_next", got.pc_next, exp.pc_next);
        check_field("exc_illegal", 32'(got.exc_illegal), 32'(exp.exc_illegal));
        check_field("exc_misaligned", 32'(got.exc_misaligned), 32'(exp.exc_misaligned));
    endtask

    task automatic print_summary();
        $display("Summary: %0d of %0d outputs checked, %0d errors, %0d pending",
                 out_count, NUM_VECTORS, error_count, exp_q.size());
    endtask

    // Exec side sampled at the edge where the transfer happens
    always @(posedge clk) begin
        if (reset_n && exec_valid && exec_ready) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Exec output at %0t arrived with no instruction pending", $time);
            end else begin
                expected = exp_q.pop_front();
                compare_exec(exec_pkt, expected);
                out_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Clock, back-pressure, stimulus and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        void'($urandom(76775));
        exec_ready = 1'b0;
        forever begin
            @(posedge clk);
            exec_ready <= ($urandom % 4) != 0;  // Stall about one cycle in four
        end
    end

    initial begin
        reset_n     = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        build_table();
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        if (fetch_ready !== 1'b1 || exec_valid !== 1'b0) begin
            error_count++;
            $display("ERR %0t: after reset fetch_ready=%b exec_valid=%b", $time,
                     fetch_ready, exec_valid);
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            fetch_valid <= 1'b1;
            fetch_pkt   <= '{pc: vectors[i].pc, instr: vectors[i].instr};
            exp_q.push_back(expected_exec(vectors[i]));
            do @(posedge clk); while (!fetch_ready);   // Hold until accepted
        end
        fetch_valid <= 1'b0;
        while (out_count < NUM_VECTORS) @(posedge clk);
        repeat (10) @(posedge clk);     // Catch any extra output
        print_summary();
        if (error_count == 0 && exp_q.size() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(NUM_VECTORS * 20 * CLK_PERIOD);
        $display("Watchdog expired before every instruction reached execute");
        print_summary();
        $display("Some tests failed");
        $finish;
    end

endmodule
